//--- all.f
hdl/fb_pkg.sv
hdl/display_timing.sv
hdl/framebuffer.sv
hdl/box_draw.sv
hdl/fb_display_top.sv
verif/tb_fb_display.sv

//--- hdl/box_draw.sv
// draws the buffer border once, starting on the first frame after reset
// corners are written twice; busy falls after the last write and stays low
`default_nettype none

module box_draw import fb_pkg::*; (
    input  wire logic                    clk_pix,
    input  wire logic                    rst_n,
    input  wire logic                    frame,
    output      logic                    box_we,
    output      logic signed [CORDW-1:0] box_x,
    output      logic signed [CORDW-1:0] box_y,
    output      logic                    busy
);

    box_state_e state;

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            state  <= IDLE;
            box_we <= 1'b0;
            busy   <= 1'b1;
            box_x  <= '0;
            box_y  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (frame) begin
                        box_x  <= '0;
                        box_y  <= '0;
                        box_we <= 1'b1;
                        state  <= TOP;
                    end
                end
                TOP: begin  // left to right along y 0
                    if (box_x < CORDW'(FB_WIDTH - 1)) begin
                        box_x <= box_x + 1'b1;
                    end else begin
                        state <= RIGHT;
                    end
                end
                RIGHT: begin
                    if (box_y < CORDW'(FB_HEIGHT - 1)) begin
                        box_y <= box_y + 1'b1;
                    end else begin
                        box_x <= '0;  // back to the origin
                        box_y <= '0;
                        state <= LEFT;
                    end
                end
                LEFT: begin
                    if (box_y < CORDW'(FB_HEIGHT - 1)) begin
                        box_y <= box_y + 1'b1;
                    end else begin
                        state <= BOTTOM;
                    end
                end
                BOTTOM: begin
                    if (box_x < CORDW'(FB_WIDTH - 1)) begin
                        box_x <= box_x + 1'b1;
                    end else begin
                        box_we <= 1'b0;
                        busy   <= 1'b0;  // last write goes out this cycle
                        state  <= DONE;
                    end
                end
                default: state <= DONE;  // stays here until reset
            endcase
        end
    end

    // the external port relies on busy staying low once drawing is over
    a_done_is_final: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        (state == DONE) |=> (state == DONE) && !busy && !box_we
    );

endmodule

`default_nettype wire

//--- hdl/display_timing.sv
// 640x480 raster generator with every output registered and aligned
// frame and line pulse at sx 0; frame only on the first line
`default_nettype none

module display_timing import fb_pkg::*; (
    input  wire logic                    clk_pix,
    input  wire logic                    rst_n,
    output      logic signed [CORDW-1:0] sx,
    output      logic signed [CORDW-1:0] sy,
    output      logic                    hsync,
    output      logic                    vsync,
    output      logic                    de,
    output      logic                    frame,
    output      logic                    line
);

    logic signed [CORDW-1:0] h_cnt;  // raster position one cycle ahead
    logic signed [CORDW-1:0] v_cnt;

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            if (h_cnt == CORDW'(H_TOTAL - 1)) begin
                h_cnt <= '0;
                if (v_cnt == CORDW'(V_TOTAL - 1)) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // registered decode keeps all outputs lined up
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sx    <= '0;
            sy    <= '0;
            hsync <= 1'b1;  // inactive
            vsync <= 1'b1;
            de    <= 1'b0;
            frame <= 1'b0;
            line  <= 1'b0;
        end else begin
            sx    <= h_cnt;
            sy    <= v_cnt;
            hsync <= !(h_cnt >= CORDW'(H_SYNC_BEG) && h_cnt < CORDW'(H_SYNC_END));
            vsync <= !(v_cnt >= CORDW'(V_SYNC_BEG) && v_cnt < CORDW'(V_SYNC_END));
            de    <= (h_cnt < CORDW'(H_RES)) && (v_cnt < CORDW'(V_RES));
            frame <= (h_cnt == '0) && (v_cnt == '0);
            line  <= (h_cnt == '0);
        end
    end

    // the raster origin follows blanking and always opens a line
    a_frame_on_line: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        frame |-> line && (sy == '0) && !$past(de)
    );

endmodule

`default_nettype wire

//--- hdl/fb_display_top.sv
// framebuffer display: built-in border drawer, then single pixel writes
// writes while busy is high are lost; VGA outputs lag the raster by two cycles
`default_nettype none

module fb_display_top import fb_pkg::*; (
    input  wire logic                    clk_pix,
    input  wire logic                    rst_n,
    input  wire logic                    we,
    input  wire logic signed [CORDW-1:0] x,
    input  wire logic signed [CORDW-1:0] y,
    input  wire logic        [CIDXW-1:0] cidx,
    output      logic                    busy,
    output      logic                    clip,
    output      logic                    vga_hsync,
    output      logic                    vga_vsync,
    output      logic                    vga_de,
    output      logic        [CHANW-1:0] vga_r,
    output      logic        [CHANW-1:0] vga_g,
    output      logic        [CHANW-1:0] vga_b
);

    logic hsync, vsync, de, frame, line;

    logic                    box_we;
    logic signed [CORDW-1:0] box_x, box_y;

    logic                    fb_we;
    logic signed [CORDW-1:0] fb_x, fb_y;
    logic        [CIDXW-1:0] fb_cidx;
    logic        [CHANW-1:0] fb_red, fb_green, fb_blue;

    logic hsync_p1, vsync_p1, de_p1;  // matched to the buffer read

    display_timing i_timing (
        .clk_pix,
        .rst_n,
        .sx    (),
        .sy    (),
        .hsync,
        .vsync,
        .de,
        .frame,
        .line
    );

    box_draw i_box (
        .clk_pix,
        .rst_n,
        .frame,
        .box_we,
        .box_x,
        .box_y,
        .busy
    );

    // drawer owns the write port until it is done
    always_comb begin
        fb_we   = busy ? box_we   : we;
        fb_x    = busy ? box_x    : x;
        fb_y    = busy ? box_y    : y;
        fb_cidx = busy ? BOX_CIDX : cidx;
    end

    framebuffer i_fb (
        .clk_pix,
        .rst_n,
        .we    (fb_we),
        .x     (fb_x),
        .y     (fb_y),
        .cidx  (fb_cidx),
        .de,
        .frame,
        .line,
        .clip,
        .red   (fb_red),
        .green (fb_green),
        .blue  (fb_blue)
    );

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            hsync_p1  <= 1'b1;
            vsync_p1  <= 1'b1;
            de_p1     <= 1'b0;
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_de    <= 1'b0;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end else begin
            hsync_p1  <= hsync;
            vsync_p1  <= vsync;
            de_p1     <= de;
            vga_hsync <= hsync_p1;
            vga_vsync <= vsync_p1;
            vga_de    <= de_p1;
            vga_r     <= fb_red;
            vga_g     <= fb_green;
            vga_b     <= fb_blue;
        end
    end

    // drawer coordinates always stay inside the buffer
    a_no_clip_while_drawing: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        busy |=> !clip
    );

endmodule

`default_nettype wire

//--- hdl/fb_pkg.sv
// constants for the 640x480 display and the 160x120 colour index buffer
// palette is fixed in logic, no memory file is loaded
`default_nettype none

package fb_pkg;

    localparam int CORDW = 16;  // signed screen and buffer coordinates

    // 640x480 raster, sync active low
    localparam int H_RES   = 640;
    localparam int H_FP    = 16;
    localparam int H_SYNC  = 96;
    localparam int H_BP    = 48;
    localparam int H_TOTAL = 800;
    localparam int V_RES   = 480;
    localparam int V_FP    = 10;
    localparam int V_SYNC  = 2;
    localparam int V_BP    = 33;
    localparam int V_TOTAL = 525;

    localparam int H_SYNC_BEG = H_RES + H_FP;
    localparam int H_SYNC_END = H_SYNC_BEG + H_SYNC;  // back porch follows
    localparam int V_SYNC_BEG = V_RES + V_FP;
    localparam int V_SYNC_END = V_SYNC_BEG + V_SYNC;

    // buffer geometry
    localparam int FB_WIDTH  = 160;
    localparam int FB_HEIGHT = 120;
    localparam int FB_SCALE  = 4;  // each word covers 4x4 screen pixels
    localparam int FB_DEPTH  = FB_WIDTH * FB_HEIGHT;
    localparam int FB_ADDRW  = 15;

    localparam int CIDXW = 4;
    localparam int CHANW = 4;

    // {red, green, blue}: red = i, green = 15 - i, blue = i ^ 4'hA
    localparam logic [3*CHANW-1:0] PALETTE [16] = '{
        12'h0FA, 12'h1EB, 12'h2D8, 12'h3C9,
        12'h4BE, 12'h5AF, 12'h69C, 12'h78D,
        12'h872, 12'h963, 12'hA50, 12'hB41,
        12'hC36, 12'hD27, 12'hE14, 12'hF05
    };

    localparam logic [CIDXW-1:0] BOX_CIDX = 4'd9;  // border colour

    typedef enum logic [2:0] {
        IDLE,
        TOP,
        RIGHT,
        LEFT,
        BOTTOM,
        DONE
    } box_state_e;

endpackage

`default_nettype wire

//--- hdl/framebuffer.sv
// 160x120 colour index buffer scanned out at 4x scale through the palette
// colour lags the timing outputs by one cycle; out of range writes are dropped
`default_nettype none

module framebuffer import fb_pkg::*; (
    input  wire logic                    clk_pix,
    input  wire logic                    rst_n,
    input  wire logic                    we,
    input  wire logic signed [CORDW-1:0] x,
    input  wire logic signed [CORDW-1:0] y,
    input  wire logic        [CIDXW-1:0] cidx,
    input  wire logic                    de,
    input  wire logic                    frame,
    input  wire logic                    line,
    output      logic                    clip,
    output      logic        [CHANW-1:0] red,
    output      logic        [CHANW-1:0] green,
    output      logic        [CHANW-1:0] blue
);

    logic [CIDXW-1:0] fb_mem [FB_DEPTH];

    logic                in_range;
    logic [FB_ADDRW-1:0] wr_addr;

    // scan-out state; registered values describe the next pixel
    logic [FB_ADDRW-1:0] row_start_q;  // first word of the current buffer row
    logic [1:0]          sub_y_q;      // line within the row
    logic [FB_ADDRW-1:0] addr_q;
    logic [1:0]          sub_x_q;      // repeat count of the current word
    logic [FB_ADDRW-1:0] row_start_c;
    logic [1:0]          sub_y_c;
    logic [FB_ADDRW-1:0] rd_addr;
    logic [1:0]          sub_x_c;

    logic [CIDXW-1:0] rd_word;
    logic             de_q;

    initial begin
        for (int i = 0; i < FB_DEPTH; i++) begin
            fb_mem[i] = '0;
        end
    end

    // write side
    always_comb begin
        in_range = !x[CORDW-1] && (x < CORDW'(FB_WIDTH))
                && !y[CORDW-1] && (y < CORDW'(FB_HEIGHT));
        wr_addr  = FB_ADDRW'(y) * FB_ADDRW'(FB_WIDTH) + FB_ADDRW'(x);
    end

    always_ff @(posedge clk_pix) begin
        if (we && in_range) begin
            fb_mem[wr_addr] <= cidx;
        end
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            clip <= 1'b0;
        end else begin
            clip <= we && !in_range;
        end
    end

    // read address for the pixel presented this cycle
    always_comb begin
        row_start_c = row_start_q;
        sub_y_c     = sub_y_q;
        rd_addr     = addr_q;
        sub_x_c     = sub_x_q;
        if (frame) begin
            row_start_c = '0;
            sub_y_c     = '0;
            rd_addr     = '0;
            sub_x_c     = '0;
        end else if (line) begin
            if (sub_y_q == 2'(FB_SCALE - 1)) begin  // step to the next row
                row_start_c = row_start_q + FB_ADDRW'(FB_WIDTH);
                sub_y_c     = '0;
            end else begin
                sub_y_c = sub_y_q + 1'b1;
            end
            rd_addr = row_start_c;
            sub_x_c = '0;
        end
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            row_start_q <= '0;
            sub_y_q     <= '0;
            addr_q      <= '0;
            sub_x_q     <= '0;
            de_q        <= 1'b0;
        end else begin
            row_start_q <= row_start_c;
            sub_y_q     <= sub_y_c;
            de_q        <= de;
            if (de && sub_x_c == 2'(FB_SCALE - 1)) begin
                addr_q  <= rd_addr + 1'b1;
                sub_x_q <= '0;
            end else if (de) begin
                addr_q  <= rd_addr;
                sub_x_q <= sub_x_c + 1'b1;
            end else begin
                addr_q  <= rd_addr;
                sub_x_q <= sub_x_c;
            end
        end
    end

    always_ff @(posedge clk_pix) begin
        if (de) begin
            rd_word <= fb_mem[rd_addr];
        end
    end

    always_comb begin
        {red, green, blue} = de_q ? PALETTE[rd_word] : '0;  // black in blanking
    end

    a_rd_addr_in_buffer: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        de |-> (rd_addr < FB_ADDRW'(FB_DEPTH))
    );

    // a clip comes only from a write outside 0..159 by 0..119
    a_clip_after_write: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        clip |-> $past(we) && ($past(x) < 0 || $past(x) >= FB_WIDTH
                               || $past(y) < 0 || $past(y) >= FB_HEIGHT)
    );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build with Verilator, run, then decide pass or fail from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_fb_display -f all.f \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vtb_fb_display > sim.log 2>&1
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || exit 1
exit 0

//--- verif/fb_cases.txt
# columns: op x y cidx, decimal buffer coordinates
# I write issued while busy, W external write, C check that buffer pixel x y shows cidx
I 20 20 5
I 21 20 6
I 80 60 12
W 10 10 3
W 11 10 7
W 100 50 15
W 159 119 2
W 0 60 4
C 10 10 3
C 11 10 7
C 12 10 0
C 10 11 0
C 100 50 15
C 159 119 2
C 158 119 9
C 0 60 4
C 0 61 9
C 20 20 0
C 80 60 0
# out of range, each must clip and leave the screen alone
W 160 5 1
W 5 120 1
W -1 5 1
W 5 -3 1
C 0 6 9
C 159 4 9
C 10 10 3

//--- verif/tb_fb_display.sv
// testbench for fb_display_top, stimulus and expected indices from verif/fb_cases.txt
// run from the project root; each batch of writes costs up to two frames
`default_nettype none

module tb_fb_display import fb_pkg::*; ();

    localparam int CLK_PERIOD   = 4;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;

    logic                    clk_pix, rst_n, we;
    logic signed [CORDW-1:0] x, y;
    logic        [CIDXW-1:0] cidx;
    logic                    busy, clip, vga_hsync, vga_vsync, vga_de;
    logic        [CHANW-1:0] vga_r, vga_g, vga_b;

    logic [CIDXW-1:0]   model [FB_DEPTH];  // expected buffer contents
    logic [3*CHANW-1:0] seen  [FB_DEPTH];  // colour shown for each word in the last scan

    byte  op_q [$];
    int   x_q [$], y_q [$], c_q [$];
    int   frames_needed = 0;
    int   clip_count    = 0;
    logic draw_done     = 1'b0;

    fb_display_top i_dut (.*);

    initial begin
        clk_pix = 1'b0;
        forever #(CLK_PERIOD / 2) clk_pix = ~clk_pix;
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic stop_with(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "%s", why);
    endtask

    // palette rule: red = i, green = 15 - i, blue = i ^ 0xA
    function automatic logic [11:0] colour_of(input logic [3:0] idx);
        return {idx, 4'd15 - idx, idx ^ 4'hA};
    endfunction

    function automatic logic in_buffer(input int vx, input int vy);
        return vx >= 0 && vx < FB_WIDTH && vy >= 0 && vy < FB_HEIGHT;
    endfunction

    task automatic load_cases();
        int               fd, code, cx, cy, cc, frames;
        byte              op;
        logic [8*128-1:0] rest;
        logic             pending;
        fd = $fopen("verif/fb_cases.txt", "r");
        if (fd == 0) stop_with("cannot open verif/fb_cases.txt");
        pending = 1'b0;
        frames  = 4;  // drawer wait plus the border scan
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", op);
            if (code == 1 && op == "#") begin
                code = $fgets(rest, fd);  // skip comment line
            end else if (code == 1) begin
                code = $fscanf(fd, " %d %d %d", cx, cy, cc);
                if (code != 3) stop_with("malformed line in the cases file");
                op_q.push_back(op);
                x_q.push_back(cx);
                y_q.push_back(cy);
                c_q.push_back(cc);
                if (op == "W") pending = 1'b1;
                if (op == "C" && pending) begin
                    frames += 2;
                    pending = 1'b0;
                end
            end
        end
        $fclose(fd);
        frames_needed = pending ? frames + 2 : frames;
    endtask

    task automatic do_write(input int wx, input int wy, input int wc, input logic exp_busy,
                            input logic exp_clip);
        repeat ($urandom_range(3, 0)) @(posedge clk_pix);  // idle gap
        @(posedge clk_pix);
        #1;
        check_val("busy", busy, exp_busy);
        we   = 1'b1;
        x    = CORDW'(wx);
        y    = CORDW'(wy);
        cidx = CIDXW'(wc);
        @(posedge clk_pix);
        #1;
        we = 1'b0;
        check_val("clip", clip, exp_clip);
    endtask

    // one full frame from a vsync fall; checks sync shape and every pixel against model
    task automatic scan_frame();
        logic        vs_prev;
        logic [11:0] rgb;
        int          n, run, lines, hs_low, vs_low, addr;
        vs_prev = 1'b0;
        @(negedge clk_pix);
        while (!(vs_prev && !vga_vsync)) begin
            vs_prev = vga_vsync;
            @(negedge clk_pix);
        end
        n = 0;
        run = 0;
        lines = 0;
        hs_low = 0;
        vs_low = 0;
        for (int i = 0; i < FRAME_CYCLES; i++) begin
            rgb = {vga_r, vga_g, vga_b};
            hs_low += !vga_hsync;
            vs_low += !vga_vsync;
            if (vga_de) begin
                if (n >= H_RES * V_RES) stop_with("vga_de high too often in one frame");
                addr = ((n / H_RES) / FB_SCALE) * FB_WIDTH + (n % H_RES) / FB_SCALE;
                seen[addr] = rgb;
                if (rgb !== colour_of(model[addr])) begin
                    check_val($sformatf("vga_rgb at screen (%0d, %0d)", n % H_RES, n / H_RES),
                              rgb, colour_of(model[addr]));
                end
                n++;
                run++;
            end else begin
                if (rgb !== '0) check_val("vga_rgb in blanking", rgb, 0);
                if (run != 0) begin
                    check_val("vga_de cycles per line", run, H_RES);
                    lines++;
                end
                run = 0;
            end
            @(negedge clk_pix);
        end
        check_val("vga_de lines per frame", lines, V_RES);
        check_val("vga_hsync low cycles per frame", hs_low, V_TOTAL * H_SYNC);
        check_val("vga_vsync low cycles per frame", vs_low, V_SYNC * H_TOTAL);
    endtask

    always @(negedge clk_pix) begin
        if (clip) clip_count++;
        if (draw_done) check_val("busy", busy, 1'b0);  // must stay low once drawn
    end

    initial begin
        wait (frames_needed > 0);
        #(longint'(frames_needed + 2) * FRAME_CYCLES * CLK_PERIOD);
        stop_with("timeout: the run took longer than the cases allow");
    end

    initial begin
        int   seed, idx, exp_clips, n;
        logic pending, out;
        seed = $urandom(32298);
        rst_n = 1'b0;
        we    = 1'b0;
        x     = '0;
        y     = '0;
        cidx  = '0;
        for (int i = 0; i < FB_DEPTH; i++) begin
            model[i] = '0;
            seen[i]  = '0;
        end
        load_cases();
        repeat (5) @(posedge clk_pix);
        #1;
        check_val("busy", busy, 1'b1);
        check_val("clip", clip, 1'b0);
        check_val("vga_hsync", vga_hsync, 1'b1);
        check_val("vga_vsync", vga_vsync, 1'b1);
        check_val("vga_de", vga_de, 1'b0);
        check_val("vga_rgb", {vga_r, vga_g, vga_b}, 0);
        rst_n = 1'b1;

        idx = 0;
        while (idx < op_q.size() && op_q[idx] == "I") begin  // lost while drawing
            do_write(x_q[idx], y_q[idx], c_q[idx], 1'b1, 1'b0);
            idx++;
        end
        n = 0;
        while (busy) begin
            @(negedge clk_pix);
            n++;
            if (n > 2 * FRAME_CYCLES) stop_with("busy did not fall within two frames");
        end
        for (int i = 0; i < FB_WIDTH; i++) begin
            model[i] = BOX_CIDX;
            model[(FB_HEIGHT - 1) * FB_WIDTH + i] = BOX_CIDX;
        end
        for (int i = 0; i < FB_HEIGHT; i++) begin
            model[i * FB_WIDTH] = BOX_CIDX;
            model[i * FB_WIDTH + FB_WIDTH - 1] = BOX_CIDX;
        end
        draw_done = 1'b1;
        scan_frame();

        pending   = 1'b0;
        exp_clips = 0;
        while (idx < op_q.size()) begin
            out = !in_buffer(x_q[idx], y_q[idx]);
            if (op_q[idx] == "W") begin
                do_write(x_q[idx], y_q[idx], c_q[idx], 1'b0, out);
                if (out) exp_clips++;
                else model[y_q[idx] * FB_WIDTH + x_q[idx]] = CIDXW'(c_q[idx]);
                pending = 1'b1;
            end else if (op_q[idx] == "C" && !out) begin
                if (pending) scan_frame();
                pending = 1'b0;
                check_val($sformatf("vga_rgb of buffer pixel (%0d, %0d)", x_q[idx], y_q[idx]),
                          seen[y_q[idx] * FB_WIDTH + x_q[idx]], colour_of(CIDXW'(c_q[idx])));
            end else begin
                stop_with($sformatf("bad line %0d in the cases file", idx));
            end
            idx++;
        end
        if (pending) scan_frame();
        check_val("clip pulse count", clip_count, exp_clips);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire
